//--- hdl/cdpwm.sv
`timescale 1ns/1ps

module cdpwm #(
    parameter WIDTH = 16,
    parameter START = 65535
) (
    input  logic             sysclk,
    input  logic             sysreset,
    input  logic             counter_event,
    output pwm_pkg::count_t  counter_value,
    output pwm_pkg::duty_t   duty,
    input  logic             duty_load,
    input  pwm_pkg::duty_t   data_in,
    output logic             pwm_signal
);

    // one countdown PWM channel.
    // the counter reload value is fixed when the channel is built.
    // the duty value is loaded by software through duty_load.
    // software can watch counter_value to time its duty updates, since a change
    // in the middle of a period may give one odd pulse.
    // the best moment to write a new duty is just after the counter reloads.
    // duty 0 keeps the output low and duty START + 1 keeps it high.

    localparam logic [WIDTH-1:0] start_value = WIDTH'(START);

    logic             event_last;
    logic             event_edge;
    logic [WIDTH-1:0] cnt;
    logic             expired;
    logic             pwm_comb;

    // rising edge detector on the prescaler level.
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            event_last <= 1'b0;
        end else begin
            event_last <= counter_event;
        end
    end

    assign event_edge = counter_event && !event_last;

    // down counter.
    // it steps once per event edge and reloads START after reaching zero.
    assign expired = (cnt == '0);

    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            cnt <= start_value;
        end else if (event_edge) begin
            if (expired) begin
                cnt <= start_value;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign counter_value = cnt;

    // duty storage.
    std_reg #(
        .WIDTH (WIDTH)
    ) u_duty_reg (
        .sysclk   (sysclk),
        .sysreset (sysreset),
        .q        (duty),
        .d        (data_in),
        .load     (duty_load)
    );

    // the compare is registered so the pin never sees compare glitches.
    assign pwm_comb = (cnt < duty);

    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            pwm_signal <= 1'b0;
        end else begin
            pwm_signal <= pwm_comb;
        end
    end

endmodule

//--- hdl/pwm_pkg.sv
`include "pwm_defines.svh"

package pwm_pkg;

    // a live channel counter value.
    typedef logic [`PWM_WIDTH-1:0] count_t;

    // a duty value.
    // the output is high while the counter is below it.
    typedef logic [`PWM_WIDTH-1:0] duty_t;

    // a prescale divider value.
    // the prescaler toggles once every prescale + 1 clocks.
    typedef logic [`PWM_PRESCALE_WIDTH-1:0] prescale_t;

    // register port address and data.
    typedef logic [`PWM_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [15:0] reg_data_t;

    // prescaler state.
    // in idle the event output is held low so the channels freeze.
    typedef enum logic {
        idle,
        run
    } prescale_state_t;

endpackage

//--- hdl/pwm_regfile.sv
`timescale 1ns/1ps
`include "pwm_defines.svh"

module pwm_regfile (
    input  logic                                  sysclk,
    input  logic                                  sysreset,
    input  logic                                  wr_en,
    input  pwm_pkg::reg_addr_t                    wr_addr,
    input  pwm_pkg::reg_data_t                    wr_data,
    input  pwm_pkg::reg_addr_t                    rd_addr,
    output pwm_pkg::reg_data_t                    rd_data,
    output logic                                  enable,
    output pwm_pkg::prescale_t                    prescale,
    output logic [`PWM_CHANNELS-1:0]              duty_load,
    output pwm_pkg::duty_t                        duty_data,
    input  pwm_pkg::duty_t [`PWM_CHANNELS-1:0]    duty,
    input  pwm_pkg::count_t [`PWM_CHANNELS-1:0]   counter_value
);

    // register addresses in the width of the address port.
    localparam pwm_pkg::reg_addr_t addr_ctrl     = pwm_pkg::reg_addr_t'(`PWM_ADDR_CTRL);
    localparam pwm_pkg::reg_addr_t addr_prescale = pwm_pkg::reg_addr_t'(`PWM_ADDR_PRESCALE);

    // control and prescale live here.
    // the duty values are stored in the channels and only decoded here.
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            enable   <= 1'b0;
            prescale <= '0;
        end else if (wr_en) begin
            if (wr_addr == addr_ctrl) begin
                enable <= wr_data[0];
            end
            if (wr_addr == addr_prescale) begin
                prescale <= wr_data[`PWM_PRESCALE_WIDTH-1:0];
            end
        end
    end

    // duty writes become a one-hot load strobe in the same cycle.
    // the channel register captures the data on that edge, so the new value
    // reads back one cycle after the write.
    always_comb begin
        duty_load = '0;
        for (int i = 0; i < `PWM_CHANNELS; i++) begin
            if (wr_en && (wr_addr == pwm_pkg::reg_addr_t'(`PWM_ADDR_DUTY0 + i))) begin
                duty_load[i] = 1'b1;
            end
        end
    end

    // every channel sees the same write data.
    assign duty_data = wr_data;

    // readback mux.
    // it is purely combinational, so rd_data follows rd_addr in the same cycle.
    // unmapped addresses read as zero.
    always_comb begin
        rd_data = '0;
        if (rd_addr == addr_ctrl) begin
            rd_data = pwm_pkg::reg_data_t'(enable);
        end
        if (rd_addr == addr_prescale) begin
            rd_data = pwm_pkg::reg_data_t'(prescale);
        end
        for (int i = 0; i < `PWM_CHANNELS; i++) begin
            if (rd_addr == pwm_pkg::reg_addr_t'(`PWM_ADDR_DUTY0 + i)) begin
                rd_data = pwm_pkg::reg_data_t'(duty[i]);
            end
            // live counters let software find the start of a period.
            if (rd_addr == pwm_pkg::reg_addr_t'(`PWM_ADDR_COUNT0 + i)) begin
                rd_data = pwm_pkg::reg_data_t'(counter_value[i]);
            end
        end
    end

endmodule

//--- hdl/pwm_timer_top.sv
`timescale 1ns/1ps
`include "pwm_defines.svh"

module pwm_timer_top (
    input  logic                         sysclk,
    input  logic                         sysreset,
    input  logic                         wr_en,
    input  pwm_pkg::reg_addr_t           wr_addr,
    input  pwm_pkg::reg_data_t           wr_data,
    input  pwm_pkg::reg_addr_t           rd_addr,
    output pwm_pkg::reg_data_t           rd_data,
    output logic [`PWM_CHANNELS-1:0]     pwm_out
);

    // control from the register file to the prescaler.
    logic               enable;
    pwm_pkg::prescale_t prescale;

    // duty write path into the channels.
    logic [`PWM_CHANNELS-1:0] duty_load;
    pwm_pkg::duty_t           duty_data;

    // shared slow event level from the prescaler.
    logic counter_event;

    // per channel state returned for readback.
    pwm_pkg::duty_t [`PWM_CHANNELS-1:0]  duty;
    pwm_pkg::count_t [`PWM_CHANNELS-1:0] counter_value;

    // register decoder and readback mux.
    pwm_regfile u_regfile (
        .sysclk        (sysclk),
        .sysreset      (sysreset),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .enable        (enable),
        .prescale      (prescale),
        .duty_load     (duty_load),
        .duty_data     (duty_data),
        .duty          (duty),
        .counter_value (counter_value)
    );

    // one prescaler drives all channels, so they stay in step.
    tick_prescaler u_prescaler (
        .sysclk        (sysclk),
        .sysreset      (sysreset),
        .enable        (enable),
        .prescale      (prescale),
        .counter_event (counter_event)
    );

    // the channels differ only in their duty register and output pin.
    for (genvar i = 0; i < `PWM_CHANNELS; i++) begin : g_channel
        cdpwm #(
            .WIDTH (`PWM_WIDTH),
            .START (`PWM_START)
        ) u_cdpwm (
            .sysclk        (sysclk),
            .sysreset      (sysreset),
            .counter_event (counter_event),
            .counter_value (counter_value[i]),
            .duty          (duty[i]),
            .duty_load     (duty_load[i]),
            .data_in       (duty_data),
            .pwm_signal    (pwm_out[i])
        );
    end

endmodule

//--- hdl/std_reg.sv
`timescale 1ns/1ps

module std_reg #(
    parameter WIDTH = 16
) (
    input  logic             sysclk,
    input  logic             sysreset,
    output logic [WIDTH-1:0] q,
    input  logic [WIDTH-1:0] d,
    input  logic             load
);

    // plain storage element with a load enable.
    // the value is captured on the clock edge where load is high.
    // otherwise it holds, and reset brings it back to zero.
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            q <= '0;
        end else if (load) begin
            q <= d;
        end
    end

    // the register is shared by several blocks.
    // its width comes from the instance, so one module serves every vector size.

endmodule

//--- hdl/tick_prescaler.sv
`timescale 1ns/1ps

module tick_prescaler (
    input  logic                sysclk,
    input  logic                sysreset,
    input  logic                enable,
    input  pwm_pkg::prescale_t  prescale,
    output logic                counter_event
);

    // state of the divider and the clocks left until the next toggle.
    pwm_pkg::prescale_state_t state;
    pwm_pkg::prescale_t       div_cnt;

    // the divider counts down from prescale and toggles counter_event at zero.
    // a full event period is therefore 2 * (prescale + 1) clocks.
    // prescale is sampled again at every reload, so a new value applies after the
    // current half period ends.
    always_ff @(posedge sysclk or posedge sysreset) begin
        if (sysreset) begin
            state         <= pwm_pkg::idle;
            div_cnt       <= '0;
            counter_event <= 1'b0;
        end else begin
            case (state)
                pwm_pkg::idle: begin
                    // the event output stays low while stopped.
                    counter_event <= 1'b0;
                    div_cnt       <= prescale;
                    if (enable) begin
                        state <= pwm_pkg::run;
                    end
                end
                default: begin
                    if (!enable) begin
                        // dropping the event level freezes all channel counters.
                        state         <= pwm_pkg::idle;
                        counter_event <= 1'b0;
                    end else if (div_cnt == '0) begin
                        counter_event <= !counter_event;
                        div_cnt       <= prescale;
                    end else begin
                        div_cnt <= div_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

//--- include/pwm_defines.svh
`ifndef PWM_DEFINES_SVH
`define PWM_DEFINES_SVH

// width of every channel counter and duty register.
`define PWM_WIDTH 16

// reload value of the channel counters.
// it is kept small so that a full PWM period stays short in simulation.
`define PWM_START 63

// number of PWM channels in the timer.
`define PWM_CHANNELS 4

// width of the prescale divider and of the register address.
`define PWM_PRESCALE_WIDTH 8
`define PWM_ADDR_WIDTH 4

// register map.
// bit 0 of the control register is the global enable.
`define PWM_ADDR_CTRL 0
`define PWM_ADDR_PRESCALE 1
// duty registers occupy 2 to 5 and counter readback 6 to 9.
`define PWM_ADDR_DUTY0 2
`define PWM_ADDR_COUNT0 6

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the PWM timer testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f vlog.f \
    --top-module pwm_timer_tb \
    -o pwm_timer_sim

sim_output=$(./obj_dir/pwm_timer_sim)
echo "$sim_output"

if grep -qx "TEST PASS" <<< "$sim_output"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- verification/pwm_input.txt
# columns: command, then decimal operands (write addr data, read addr expected, wait cycles,
# measure channel high_clocks, readle addr limit)
# after reset the registers are clear and the counters hold the start value.
read 0 0
read 1 0
read 2 0
read 3 0
read 4 0
read 5 0
read 6 63
read 7 63
read 8 63
read 9 63
measure 0 0
measure 1 0
measure 2 0
measure 3 0
# register writes read back, and an unmapped address reads zero.
write 1 5
read 1 5
write 2 16
read 2 16
write 3 40
read 3 40
write 4 100
read 4 100
write 5 7
read 5 7
read 12 0
# duty ratios with prescale 0 on two channels at once.
write 1 0
write 0 1
read 0 1
measure 0 32
measure 1 80
# extremes: duty 0 stays low and duty 64 stays high.
write 4 0
write 5 64
measure 2 0
measure 3 128
# prescale 2 stretches each event period to 6 clocks.
write 1 2
write 2 10
measure 0 60
# clearing the enable freezes the counters.
write 0 0
wait 4
readle 6 63
readle 9 63

//--- verification/pwm_timer_tb.sv
`timescale 1ns/1ps
`include "pwm_defines.svh"

module pwm_timer_tb;

    // command codes for the lines of the stimulus file.
    localparam int cmd_write   = 0;
    localparam int cmd_read    = 1;
    localparam int cmd_wait    = 2;
    localparam int cmd_measure = 3;
    localparam int cmd_readle  = 4;

    logic                     sysclk;
    logic                     sysreset;
    logic                     wr_en;
    pwm_pkg::reg_addr_t       wr_addr;
    pwm_pkg::reg_data_t       wr_data;
    pwm_pkg::reg_addr_t       rd_addr;
    pwm_pkg::reg_data_t       rd_data;
    logic [`PWM_CHANNELS-1:0] pwm_out;

    // parsed commands, one entry per file line.
    int cmd_q[$];
    int arg_a_q[$];
    int arg_b_q[$];

    int error_count;
    int cycle_count;
    int cycle_limit;
    int last_prescale;

    pwm_timer_top u_dut (
        .sysclk   (sysclk),
        .sysreset (sysreset),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .pwm_out  (pwm_out)
    );

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;
    end

    // a full PWM period is START + 1 event periods of 2 * (prescale + 1) clocks.
    function automatic int pwm_period(input int prescale);
        return (`PWM_START + 1) * 2 * (prescale + 1);
    endfunction

    // reads the whole stimulus file and works out the cycle limit from its length.
    task automatic load_commands();
        int fd;
        int n;
        int a;
        int b;
        int ps;
        int total;
        bit done;
        reg [8*16-1:0]  word;
        reg [8*256-1:0] rest;
        fd = $fopen("verification/pwm_input.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open stimulus file verification/pwm_input.txt");
            error_count++;
        end else begin
            ps = 0;
            // the two reset cycles come first.
            total = 2;
            done = 1'b0;
            while (!done) begin
                n = $fscanf(fd, "%s", word);
                if (n != 1) begin
                    done = 1'b1;
                end else if (word == "#") begin
                    n = $fgets(rest, fd);
                end else if (word == "wait") begin
                    n = $fscanf(fd, "%d", a);
                    cmd_q.push_back(cmd_wait);
                    arg_a_q.push_back(a);
                    arg_b_q.push_back(0);
                    total += a;
                end else begin
                    n = $fscanf(fd, "%d %d", a, b);
                    arg_a_q.push_back(a);
                    arg_b_q.push_back(b);
                    if (word == "write") begin
                        cmd_q.push_back(cmd_write);
                        if (a == `PWM_ADDR_PRESCALE) ps = b % 256;
                        total += 1;
                    end else if (word == "read") begin
                        cmd_q.push_back(cmd_read);
                        total += 1;
                    end else if (word == "measure") begin
                        cmd_q.push_back(cmd_measure);
                        // settle, sync over at most a period, then one period counted.
                        total += 2 * pwm_period(ps) + 8;
                    end else if (word == "readle") begin
                        cmd_q.push_back(cmd_readle);
                        total += 11;
                    end else begin
                        $display("error: unknown command in stimulus file");
                        error_count++;
                        done = 1'b1;
                    end
                end
            end
            $fclose(fd);
            cycle_limit = 2 * total;
        end
    endtask

    // one write strobe, driven just after the clock edge.
    task automatic write_reg(input int addr, input int data);
        wr_addr = pwm_pkg::reg_addr_t'(addr);
        wr_data = pwm_pkg::reg_data_t'(data);
        wr_en   = 1'b1;
        @(posedge sysclk);
        #1 wr_en = 1'b0;
        if (addr == `PWM_ADDR_PRESCALE) last_prescale = data % 256;
    endtask

    // the read port is combinational, so rd_data is sampled on the falling edge.
    task automatic check_read(input int addr, input int expected);
        rd_addr = pwm_pkg::reg_addr_t'(addr);
        @(negedge sysclk);
        if (rd_data !== pwm_pkg::reg_data_t'(expected)) begin
            $display("FAILED at %0t: read of address %0d gave %0d, expected %0d",
                     $time, addr, rd_data, expected);
            error_count++;
        end
        @(posedge sysclk);
        #1;
    endtask

    task automatic wait_cycles(input int cycles);
        repeat (cycles) @(posedge sysclk);
        #1;
    endtask

    // counts the high clocks of one channel over exactly one PWM period.
    // the window starts at a rising edge of the output when one comes within a period.
    // with a constant output there is no edge, and any window of a period will do.
    task automatic measure_high(input int ch, input int expected);
        int period;
        int tries;
        int remaining;
        int high_count;
        bit found;
        logic prev;
        logic cur;
        period = pwm_period(last_prescale);
        // the registered output lags a duty write by one clock.
        repeat (2) @(posedge sysclk);
        @(negedge sysclk);
        prev  = pwm_out[ch];
        found = 1'b0;
        tries = 0;
        while (!found && tries < period + 4) begin
            @(negedge sysclk);
            cur = pwm_out[ch];
            if (cur && !prev) found = 1'b1;
            prev = cur;
            tries++;
        end
        if (found) begin
            high_count = 1;
            remaining  = period - 1;
        end else begin
            high_count = 0;
            remaining  = period;
        end
        repeat (remaining) begin
            @(negedge sysclk);
            if (pwm_out[ch]) high_count++;
        end
        @(posedge sysclk);
        #1;
        if (high_count != expected) begin
            $display("FAILED at %0t: channel %0d was high %0d of %0d clocks, expected %0d",
                     $time, ch, high_count, period, expected);
            error_count++;
        end
    endtask

    // two counter reads some clocks apart must agree while the timer is stopped.
    task automatic check_frozen(input int addr, input int limit);
        int first;
        int second;
        rd_addr = pwm_pkg::reg_addr_t'(addr);
        @(negedge sysclk);
        first = rd_data;
        repeat (8) @(posedge sysclk);
        @(negedge sysclk);
        second = rd_data;
        @(posedge sysclk);
        #1;
        if (first != second) begin
            $display("FAILED at %0t: address %0d moved from %0d to %0d while disabled",
                     $time, addr, first, second);
            error_count++;
        end
        if (first > limit) begin
            $display("FAILED at %0t: address %0d read %0d, above the limit %0d",
                     $time, addr, first, limit);
            error_count++;
        end
    endtask

    task automatic run_commands();
        for (int i = 0; i < cmd_q.size(); i++) begin
            case (cmd_q[i])
                cmd_write:   write_reg(arg_a_q[i], arg_b_q[i]);
                cmd_read:    check_read(arg_a_q[i], arg_b_q[i]);
                cmd_wait:    wait_cycles(arg_a_q[i]);
                cmd_measure: measure_high(arg_a_q[i], arg_b_q[i]);
                default:     check_frozen(arg_a_q[i], arg_b_q[i]);
            endcase
        end
    endtask

    // the run is stopped once the clock count passes the limit from the file.
    always @(posedge sysclk) begin
        if (cycle_limit > 0) begin
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                $display("timeout: test did not finish");
                error_count++;
                $display("run stopped with %0d errors", error_count);
                $display("TEST FAIL");
                $finish;
            end
        end
    end

    initial begin
        sysreset      = 1'b1;
        wr_en         = 1'b0;
        wr_addr       = '0;
        wr_data       = '0;
        rd_addr       = '0;
        error_count   = 0;
        cycle_count   = 0;
        cycle_limit   = 0;
        last_prescale = 0;
        load_commands();
        repeat (2) @(posedge sysclk);
        #1 sysreset = 1'b0;
        run_commands();
        $display("run finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
hdl/pwm_pkg.sv
hdl/std_reg.sv
hdl/tick_prescaler.sv
hdl/cdpwm.sv
hdl/pwm_regfile.sv
hdl/pwm_timer_top.sv
verification/pwm_timer_tb.sv
